// File: hdl/z80_arch_pkg.sv
package z80_arch_pkg;

    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 16;
    localparam int REG_SEL_W = 3;

    // Register numbers as they appear in the opcode fields
    typedef enum logic [2:0] {
        REG_B = 3'd0,
        REG_C = 3'd1,
        REG_D = 3'd2,
        REG_E = 3'd3,
        REG_H = 3'd4,
        REG_L = 3'd5,
        REG_F = 3'd6,       // No 8-bit code of its own in the ISA
        REG_A = 3'd7
    } reg_code_e;

    // Flag bits in F
    localparam int FLAG_C  = 0;
    localparam int FLAG_N  = 1;
    localparam int FLAG_PV = 2;
    localparam int FLAG_H  = 4;
    localparam int FLAG_Z  = 6;
    localparam int FLAG_S  = 7;

    // Condition field of JP cc
    typedef enum logic [2:0] {
        COND_NZ, COND_Z,
        COND_NC, COND_C,
        COND_PO, COND_PE,
        COND_P,  COND_M
    } cond_e;

endpackage

// File: hdl/z80_isa_pkg.sv
package z80_isa_pkg;

    // ------------------------------------------------
    // ALU operations in opcode field order
    // ------------------------------------------------

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1,
        ALU_SUB = 3'd2,
        ALU_SBC = 3'd3,
        ALU_AND = 3'd4,
        ALU_XOR = 3'd5,
        ALU_OR  = 3'd6,
        ALU_CP  = 3'd7      // SUB without the write to A
    } alu_op_e;

    // ------------------------------------------------
    // Decoded instruction classes
    // ------------------------------------------------

    typedef enum logic [3:0] {
        OP_NOP,
        OP_HALT,
        OP_LD_R_N,          // 00_rrr_110
        OP_LD_R_R,          // 01_ddd_sss
        OP_LD_A_MEM,        // 3A nn
        OP_LD_MEM_A,        // 32 nn
        OP_ALU_R,           // 10_ooo_sss
        OP_ALU_N,           // 11_ooo_110
        OP_JP,              // C3 nn
        OP_JP_CC,           // 11_ccc_010
        OP_OUT_N,           // D3 n
        OP_IN_N,            // DB n
        OP_UNSUPPORTED      // Runs as a two-cycle NOP
    } op_group_e;

    // Sequencer states
    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC1,
        S_EXEC2,
        S_EXEC3,
        S_HALTED            // Left only by reset
    } seq_state_e;

endpackage

// File: hdl/z80_regfile_if.sv
`timescale 1ns/10ps

interface z80_regfile_if import z80_arch_pkg::*; ();

    logic                 wr_en;        // 8-bit register write
    logic                 flag_wr_en;   // F write from the ALU
    logic [REG_SEL_W-1:0] sel;
    logic [DATA_W-1:0]    wr_data;
    logic [DATA_W-1:0]    flag_data;
    logic [DATA_W-1:0]    rd_data;      // Register named by sel
    logic [DATA_W-1:0]    acc;
    logic [DATA_W-1:0]    flags;
    cond_e                cond;
    logic                 cond_true;

    // Sequencer side
    modport ctrl (
        output wr_en, flag_wr_en, sel, wr_data, flag_data, cond,
        input  rd_data, acc, flags, cond_true
    );

    // Register file side
    modport regs (
        input  wr_en, flag_wr_en, sel, wr_data, flag_data, cond,
        output rd_data, acc, flags, cond_true
    );

endinterface

// File: hdl/z80_regs.sv
`timescale 1ns/10ps

module z80_regs import z80_arch_pkg::*; (
    input  logic       pin_clk,
    input  logic       pin_reset,
    z80_regfile_if.regs rf
);

    logic [DATA_W-1:0] regs_q [2**REG_SEL_W];   // B C D E H L F A
    logic              flag_s;
    logic              flag_z;
    logic              flag_pv;
    logic              flag_c;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------

    always_ff @(posedge pin_clk) begin
        if (pin_reset) begin
            for (int i = 0; i < 2**REG_SEL_W; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (rf.wr_en) begin
                regs_q[rf.sel] <= rf.wr_data;       // Code 6 lands in F
            end
            if (rf.flag_wr_en) begin
                regs_q[REG_F] <= rf.flag_data;
            end
        end
    end

    assign rf.rd_data = regs_q[rf.sel];
    assign rf.acc     = regs_q[REG_A];
    assign rf.flags   = regs_q[REG_F];

    // ------------------------------------------------
    // Condition evaluation
    // ------------------------------------------------

    assign flag_s  = regs_q[REG_F][FLAG_S];
    assign flag_z  = regs_q[REG_F][FLAG_Z];
    assign flag_pv = regs_q[REG_F][FLAG_PV];
    assign flag_c  = regs_q[REG_F][FLAG_C];

    always_comb begin
        unique case (rf.cond)
            COND_NZ: rf.cond_true = !flag_z;
            COND_Z:  rf.cond_true =  flag_z;
            COND_NC: rf.cond_true = !flag_c;
            COND_C:  rf.cond_true =  flag_c;
            COND_PO: rf.cond_true = !flag_pv;       // Parity odd
            COND_PE: rf.cond_true =  flag_pv;
            COND_P:  rf.cond_true = !flag_s;        // Plus
            COND_M:  rf.cond_true =  flag_s;        // Minus
        endcase
    end

    // The sequencer must not aim a register write and a flag write at F together
    a_no_f_clash: assert property (@(posedge pin_clk) disable iff (pin_reset)
        !(rf.wr_en && rf.flag_wr_en && rf.sel == REG_F));

endmodule

// File: hdl/z80_alu.sv
`timescale 1ns/10ps

module z80_alu import z80_arch_pkg::*, z80_isa_pkg::*; (
    input  alu_op_e           op_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    input  logic              carry_i,
    output logic [DATA_W-1:0] result_o,
    output logic [DATA_W-1:0] flags_o
);

    logic              cin;
    logic [4:0]        half;        // Low nibble with carry out of bit 3
    logic [DATA_W:0]   wide;        // Full byte with carry out of bit 7
    logic [DATA_W-1:0] res;
    logic [DATA_W-1:0] xy_src;      // Source of the undocumented bits 5 and 3
    logic              hf;
    logic              vf;
    logic              nf;
    logic              cf;

    assign cin = (op_i == ALU_ADC || op_i == ALU_SBC) ? carry_i : 1'b0;

    // ------------------------------------------------
    // Result and raw flags
    // ------------------------------------------------

    always_comb begin
        half = '0;
        wide = '0;
        res  = '0;
        hf   = 1'b0;
        vf   = 1'b0;
        nf   = 1'b0;
        cf   = 1'b0;
        unique case (op_i)
            ALU_ADD, ALU_ADC: begin
                half = {1'b0, a_i[3:0]} + {1'b0, b_i[3:0]} + 5'(cin);
                wide = {1'b0, a_i} + {1'b0, b_i} + 9'(cin);
                res  = wide[DATA_W-1:0];
                hf   = half[4];
                cf   = wide[DATA_W];
                vf   = (a_i[7] == b_i[7]) && (res[7] != a_i[7]);   // Same signs in
            end
            ALU_SUB, ALU_SBC, ALU_CP: begin
                half = {1'b0, a_i[3:0]} - {1'b0, b_i[3:0]} - 5'(cin);
                wide = {1'b0, a_i} - {1'b0, b_i} - 9'(cin);
                res  = wide[DATA_W-1:0];
                hf   = half[4];                 // Borrow from bit 4
                cf   = wide[DATA_W];
                vf   = (a_i[7] != b_i[7]) && (res[7] != a_i[7]);
                nf   = 1'b1;
            end
            ALU_AND: begin
                res = a_i & b_i;
                hf  = 1'b1;
                vf  = ~^res;                    // Even parity
            end
            ALU_XOR: begin
                res = a_i ^ b_i;
                vf  = ~^res;
            end
            ALU_OR: begin
                res = a_i | b_i;
                vf  = ~^res;
            end
        endcase
    end

    // CP takes bits 5 and 3 from the operand, not from the difference
    assign xy_src = (op_i == ALU_CP) ? b_i : res;

    // ------------------------------------------------
    // Flag byte
    // ------------------------------------------------

    always_comb begin
        flags_o          = '0;
        flags_o[FLAG_S]  = res[7];
        flags_o[FLAG_Z]  = (res == '0);
        flags_o[5]       = xy_src[5];
        flags_o[FLAG_H]  = hf;
        flags_o[3]       = xy_src[3];
        flags_o[FLAG_PV] = vf;
        flags_o[FLAG_N]  = nf;
        flags_o[FLAG_C]  = cf;
    end

    assign result_o = res;

endmodule

// File: hdl/z80_control.sv
`timescale 1ns/10ps

module z80_control import z80_arch_pkg::*, z80_isa_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              pin_clk,
    input  logic              pin_reset,
    input  logic [DATA_W-1:0] mem_rdata_i,
    output logic [ADDR_W-1:0] mem_addr_o,
    output logic              mem_wr_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    output logic [ADDR_W-1:0] port_addr_o,
    input  logic [DATA_W-1:0] port_rdata_i,
    output logic [DATA_W-1:0] port_data_o,
    output logic              port_wr_o,
    z80_regfile_if.ctrl       rf,
    output alu_op_e           alu_op_o,
    output logic [DATA_W-1:0] alu_a_o,
    output logic [DATA_W-1:0] alu_b_o,
    output logic              alu_carry_o,
    input  logic [DATA_W-1:0] alu_result_i,
    input  logic [DATA_W-1:0] alu_flags_i
);

    seq_state_e           state_q;
    op_group_e            group_q;
    logic [ADDR_W-1:0]    pc_q;
    logic [DATA_W-1:0]    port_addr_q;
    logic [DATA_W-1:0]    opcode_q;
    logic [DATA_W-1:0]    operand_q;      // Source register or ALU operand
    logic [ADDR_W-1:0]    cursor_q;       // Address taken from nn
    logic [REG_SEL_W-1:0] dst;
    logic [REG_SEL_W-1:0] src;
    logic                 use_cursor;

    function automatic op_group_e decode_op(input logic [DATA_W-1:0] op);
        op_group_e grp;
        grp = OP_UNSUPPORTED;
        casez (op)
            8'h00:       grp = OP_NOP;
            8'h76:       grp = OP_HALT;
            8'h32:       grp = OP_LD_MEM_A;
            8'h3A:       grp = OP_LD_A_MEM;
            8'hC3:       grp = OP_JP;
            8'hD3:       grp = OP_OUT_N;
            8'hDB:       grp = OP_IN_N;
            8'b00???110: grp = (op[5:3] == 3'b110) ? OP_UNSUPPORTED : OP_LD_R_N;
            8'b01??????: grp = (op[5:3] == 3'b110 || op[2:0] == 3'b110) ?
                               OP_UNSUPPORTED : OP_LD_R_R;
            8'b10??????: grp = (op[2:0] == 3'b110) ? OP_UNSUPPORTED : OP_ALU_R;
            8'b11???110: grp = OP_ALU_N;
            8'b11???010: grp = OP_JP_CC;
            default:     grp = OP_UNSUPPORTED;
        endcase
        return grp;
    endfunction

    assign dst = opcode_q[5:3];
    assign src = opcode_q[2:0];

    // ------------------------------------------------
    // Sequencer and program counter
    // ------------------------------------------------

    always_ff @(posedge pin_clk) begin
        if (pin_reset) begin
            state_q     <= S_FETCH;
            group_q     <= OP_NOP;
            pc_q        <= RESET_PC;
            port_addr_q <= '0;
        end else begin
            unique case (state_q)
                S_FETCH: begin
                    group_q <= decode_op(mem_rdata_i);
                    pc_q    <= pc_q + 1'b1;
                    state_q <= (decode_op(mem_rdata_i) == OP_HALT) ? S_HALTED : S_EXEC1;
                end
                S_EXEC1: begin
                    state_q <= S_FETCH;
                    case (group_q)
                        OP_LD_R_N, OP_ALU_N: pc_q <= pc_q + 1'b1;
                        OP_OUT_N: begin
                            pc_q        <= pc_q + 1'b1;
                            port_addr_q <= mem_rdata_i;
                        end
                        OP_IN_N: begin
                            pc_q        <= pc_q + 1'b1;
                            port_addr_q <= mem_rdata_i;     // On pin_pa next cycle
                            state_q     <= S_EXEC2;
                        end
                        OP_LD_R_R, OP_ALU_R: state_q <= S_EXEC2;
                        OP_LD_A_MEM, OP_LD_MEM_A, OP_JP, OP_JP_CC: begin
                            pc_q    <= pc_q + 1'b1;         // Low byte of nn
                            state_q <= S_EXEC2;
                        end
                        default: state_q <= S_FETCH;
                    endcase
                end
                S_EXEC2: begin
                    state_q <= S_FETCH;
                    if (group_q inside {OP_LD_A_MEM, OP_LD_MEM_A, OP_JP, OP_JP_CC}) begin
                        pc_q    <= pc_q + 1'b1;             // High byte of nn
                        state_q <= S_EXEC3;
                    end
                end
                S_EXEC3: begin
                    state_q <= S_FETCH;
                    if (group_q == OP_JP || (group_q == OP_JP_CC && rf.cond_true)) begin
                        pc_q <= cursor_q;
                    end
                end
                S_HALTED: state_q <= S_HALTED;
                default:  state_q <= S_FETCH;
            endcase
        end
    end

    // Opcode, operand and address bytes
    always_ff @(posedge pin_clk) begin
        if (state_q == S_FETCH) opcode_q <= mem_rdata_i;
        if (state_q == S_EXEC1) begin
            operand_q      <= rf.rd_data;
            cursor_q[7:0]  <= mem_rdata_i;
        end
        if (state_q == S_EXEC2) cursor_q[15:8] <= mem_rdata_i;
    end

    // ------------------------------------------------
    // Register file strobes
    // ------------------------------------------------

    always_comb begin
        rf.wr_en      = 1'b0;
        rf.flag_wr_en = 1'b0;
        rf.sel        = REG_A;
        rf.wr_data    = mem_rdata_i;
        rf.flag_data  = alu_flags_i;
        rf.cond       = cond_e'(opcode_q[5:3]);
        if (state_q == S_EXEC1 && group_q inside {OP_LD_R_R, OP_ALU_R}) begin
            rf.sel = src;                           // Source read
        end
        if (state_q == S_EXEC1 && group_q == OP_LD_R_N) begin
            rf.wr_en = 1'b1;
            rf.sel   = dst;
        end
        if (state_q == S_EXEC2 && group_q == OP_LD_R_R) begin
            rf.wr_en   = 1'b1;
            rf.sel     = dst;
            rf.wr_data = operand_q;
        end
        if ((state_q == S_EXEC2 && group_q == OP_ALU_R) ||
            (state_q == S_EXEC1 && group_q == OP_ALU_N)) begin
            rf.wr_en      = (alu_op_o != ALU_CP);   // CP keeps A
            rf.flag_wr_en = 1'b1;
            rf.wr_data    = alu_result_i;
        end
        if (state_q == S_EXEC3 && group_q == OP_LD_A_MEM) rf.wr_en = 1'b1;
        if (state_q == S_EXEC2 && group_q == OP_IN_N) begin
            rf.wr_en   = 1'b1;
            rf.wr_data = port_rdata_i;
        end
    end

    // ------------------------------------------------
    // ALU operands, memory bus and ports
    // ------------------------------------------------

    assign alu_op_o    = alu_op_e'(opcode_q[5:3]);
    assign alu_a_o     = rf.acc;
    assign alu_b_o     = (group_q == OP_ALU_N) ? mem_rdata_i : operand_q;
    assign alu_carry_o = rf.flags[FLAG_C];

    assign use_cursor  = (state_q == S_EXEC3) && (group_q inside {OP_LD_A_MEM, OP_LD_MEM_A});
    assign mem_addr_o  = use_cursor ? cursor_q : pc_q;
    assign mem_wr_o    = (state_q == S_EXEC3) && (group_q == OP_LD_MEM_A);
    assign mem_wdata_o = rf.acc;

    assign port_wr_o   = (state_q == S_EXEC1) && (group_q == OP_OUT_N);
    assign port_data_o = rf.acc;
    assign port_addr_o = port_wr_o ? {{(ADDR_W-DATA_W){1'b0}}, mem_rdata_i}
                                   : {{(ADDR_W-DATA_W){1'b0}}, port_addr_q};

    a_wr_exclusive: assert property (@(posedge pin_clk) disable iff (pin_reset)
        !(mem_wr_o && port_wr_o));

    a_halt_sticky: assert property (@(posedge pin_clk) disable iff (pin_reset)
        (state_q == S_HALTED) |=> (state_q == S_HALTED));

endmodule

// File: hdl/z80.sv
`timescale 1ns/10ps

module z80 import z80_arch_pkg::*, z80_isa_pkg::*; #(
    parameter logic [ADDR_W-1:0] RESET_PC = '0
) (
    input  logic              pin_clk,
    input  logic              pin_reset,

    // Memory bus
    input  logic [DATA_W-1:0] pin_i,
    output logic [ADDR_W-1:0] pin_a,
    output logic              pin_enw,      // One-cycle write strobe
    output logic [DATA_W-1:0] pin_o,

    // I/O ports
    output logic [ADDR_W-1:0] pin_pa,
    input  logic [DATA_W-1:0] pin_pi,
    output logic [DATA_W-1:0] pin_po,
    output logic              pin_pw
);

    alu_op_e           alu_op;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic              alu_carry;
    logic [DATA_W-1:0] alu_result;
    logic [DATA_W-1:0] alu_flags;

    z80_regfile_if rf_if ();

    z80_control #(.RESET_PC(RESET_PC)) u_control (
        .pin_clk      (pin_clk),      .pin_reset    (pin_reset),
        .mem_rdata_i  (pin_i),        .mem_addr_o   (pin_a),
        .mem_wr_o     (pin_enw),      .mem_wdata_o  (pin_o),
        .port_addr_o  (pin_pa),       .port_rdata_i (pin_pi),
        .port_data_o  (pin_po),       .port_wr_o    (pin_pw),
        .rf           (rf_if.ctrl),
        .alu_op_o     (alu_op),       .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),        .alu_carry_o  (alu_carry),
        .alu_result_i (alu_result),   .alu_flags_i  (alu_flags)
    );

    z80_regs u_regs (.pin_clk(pin_clk), .pin_reset(pin_reset), .rf(rf_if.regs));

    z80_alu u_alu (
        .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .carry_i(alu_carry),
        .result_o(alu_result), .flags_o(alu_flags)
    );

endmodule

// File: sim/tb_z80.sv
`timescale 1ns/10ps

module tb_z80;

    localparam int          CLK_PERIOD = 40;
    localparam int          DRIVE_DLY  = 2;
    localparam logic [15:0] RESET_PC   = 16'h0000;
    localparam int          ALU_PAIRS  = 20;
    localparam logic [7:0]  MARK_TRUE  = 8'hA5;
    localparam logic [7:0]  MARK_FALSE = 8'h5A;

    logic        pin_clk;
    logic        pin_reset;
    logic [7:0]  pin_i;
    logic [15:0] pin_a;
    logic        pin_enw;
    logic [7:0]  pin_o;
    logic [15:0] pin_pa;
    logic [7:0]  pin_pi;
    logic [7:0]  pin_po;
    logic        pin_pw;

    logic [7:0]  mem [65536];
    logic [31:0] port_log [$];      // {00, port, data} per pin_pw pulse
    logic [31:0] wr_log [$];        // {00, address, data} per pin_enw pulse
    logic [31:0] exp_ports [$];
    logic [15:0] wp;                // Program load pointer
    logic [15:0] watch_pa;
    logic        pa_seen;
    logic [15:0] first_fetch;
    int          cycle_cnt = 0;
    int          budget = 105;      // Initial reset plus margin
    int          err_cnt;
    int          test_cnt;
    int          test_err;

    z80 #(.RESET_PC(RESET_PC)) UUT (
        .pin_clk(pin_clk), .pin_reset(pin_reset),
        .pin_i(pin_i), .pin_a(pin_a), .pin_enw(pin_enw), .pin_o(pin_o),
        .pin_pa(pin_pa), .pin_pi(pin_pi), .pin_po(pin_po), .pin_pw(pin_pw)
    );

    assign pin_i = mem[pin_a];      // Combinational read

    initial begin
        pin_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pin_clk = ~pin_clk;
    end

    always @(posedge pin_clk) cycle_cnt <= cycle_cnt + 1;

    // ------------------------------------------------
    // Bus and port monitor at mid-cycle
    // ------------------------------------------------

    always @(negedge pin_clk) begin
        if (pin_enw) begin
            mem[pin_a] = pin_o;
            wr_log.push_back({8'h00, pin_a, pin_o});
        end
        if (pin_pw) port_log.push_back({8'h00, pin_pa, pin_po});
        if (!pin_pw && pin_pa == watch_pa) pa_seen = 1'b1;
    end

    initial begin
        wait (cycle_cnt > budget);
        $display("Watchdog expired at cycle %0d, the DUT did not halt in time", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------
    // Reference model
    // ------------------------------------------------

    // Returns {flags, result}
    function automatic logic [15:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                              input logic [7:0] b, input logic cin);
        int         sum;
        int         ssum;
        int         nib;
        int         ones;
        logic       c_used;
        logic [7:0] r;
        logic [7:0] f;
        c_used = (op == 3'd1 || op == 3'd3) ? cin : 1'b0;
        f = 8'h00;
        ssum = 0;
        case (op)
            3'd0, 3'd1: begin
                sum  = int'(a) + int'(b) + int'(c_used);
                ssum = int'($signed(a)) + int'($signed(b)) + int'(c_used);
                nib  = int'(a[3:0]) + int'(b[3:0]) + int'(c_used);
                f[0] = (sum > 255);
                f[4] = (nib > 15);
            end
            3'd2, 3'd3, 3'd7: begin
                sum  = int'(a) - int'(b) - int'(c_used);
                ssum = int'($signed(a)) - int'($signed(b)) - int'(c_used);
                nib  = int'(a[3:0]) - int'(b[3:0]) - int'(c_used);
                f[0] = (sum < 0);       // Borrow
                f[4] = (nib < 0);
                f[1] = 1'b1;
            end
            3'd4: begin
                sum  = int'(a & b);
                f[4] = 1'b1;
            end
            3'd5:    sum = int'(a ^ b);
            default: sum = int'(a | b);
        endcase
        r = 8'(sum);
        ones = 0;
        for (int k = 0; k < 8; k++) ones += int'(r[k]);
        if (op inside {3'd4, 3'd5, 3'd6}) f[2] = (ones % 2 == 0);
        else f[2] = (ssum > 127 || ssum < -128);
        f[7] = r[7];
        f[6] = (r == 8'h00);
        f[5] = (op == 3'd7) ? b[5] : r[5];
        f[3] = (op == 3'd7) ? b[3] : r[3];
        return {f, r};
    endfunction

    function automatic logic cond_holds(input logic [7:0] f, input logic [2:0] cc);
        logic bit_val;
        case (cc[2:1])
            2'd0:    bit_val = f[6];    // Z
            2'd1:    bit_val = f[0];    // C
            2'd2:    bit_val = f[2];    // P/V
            default: bit_val = f[7];    // S
        endcase
        return cc[0] ? bit_val : !bit_val;
    endfunction

    // ------------------------------------------------
    // Program building and running
    // ------------------------------------------------

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        err_cnt++;
        test_err++;
        $display("Error %s: expected %h, actual %h", name, exp, act);
    endtask

    task automatic emit(input logic [7:0] b);
        mem[wp] = b;
        wp = wp + 16'd1;
    endtask

    task automatic expect_port(input logic [7:0] port, input logic [7:0] data);
        exp_ports.push_back({16'h0000, port, data});
    endtask

    task automatic emit_out(input logic [7:0] port, input logic [7:0] data);
        emit(8'hD3);
        emit(port);
        expect_port(port, data);
    endtask

    // Marker byte out on a port as chosen by JP cc
    task automatic emit_probe(input logic [2:0] cc, input logic [7:0] port,
                              input logic [7:0] flags);
        logic [15:0] target;
        target = wp + 16'd7;
        emit(8'h3E);
        emit(MARK_TRUE);
        emit({2'b11, cc, 3'b010});
        emit(target[7:0]);
        emit(target[15:8]);
        emit(8'h3E);
        emit(MARK_FALSE);
        emit_out(port, cond_holds(flags, cc) ? MARK_TRUE : MARK_FALSE);
    endtask

    task automatic begin_program();
        @(posedge pin_clk);
        #DRIVE_DLY;
        pin_reset = 1'b1;
        wp = RESET_PC;
        port_log.delete();
        wr_log.delete();
        exp_ports.delete();
        pa_seen = 1'b0;
    endtask

    // Release reset and wait until pin_a holds still for 8 cycles
    task automatic run_program(input int extra_cycles);
        int          stable;
        logic [15:0] last_a;
        budget += int'(wp - RESET_PC) * 4 + 30 + extra_cycles;
        repeat (5) @(posedge pin_clk);
        #DRIVE_DLY;
        pin_reset = 1'b0;
        @(negedge pin_clk);
        first_fetch = pin_a;
        last_a = pin_a;
        stable = 0;
        while (stable < 8) begin
            @(negedge pin_clk);
            if (pin_a == last_a && !pin_enw && !pin_pw) stable++;
            else stable = 0;
            last_a = pin_a;
        end
        repeat (extra_cycles) @(posedge pin_clk);
    endtask

    task automatic compare_ports(input string name);
        if (port_log.size() != exp_ports.size()) begin
            report_mismatch({name, " port count"}, 32'(exp_ports.size()),
                            32'(port_log.size()));
        end else begin
            foreach (exp_ports[k]) begin
                if (port_log[k] !== exp_ports[k]) report_mismatch(name, exp_ports[k], port_log[k]);
            end
        end
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (test_err == 0) $display("%-16s ok", name);
        else $display("%-16s %0d errors", name, test_err);
    endtask

    // ------------------------------------------------
    // Tests
    // ------------------------------------------------

    task automatic loads_test();
        logic [7:0] val [8];
        test_err = 0;
        begin_program();
        for (int r = 0; r < 8; r++) begin
            val[r] = 8'($urandom);
            if (r != 6) begin
                emit({2'b00, 3'(r), 3'b110});
                emit(val[r]);
            end
        end
        emit_out(8'h20, val[7]);
        for (int r = 0; r < 6; r++) begin
            emit({5'b01111, 3'(r)});            // LD A,r
            emit_out(8'(8'h10 + r), val[r]);
        end
        emit(8'h43);                            // LD B,E
        emit(8'h60);                            // LD H,B
        emit(8'h7C);                            // LD A,H
        emit_out(8'h30, val[3]);
        emit(8'h76);
        run_program(0);
        compare_ports("loads");
        finish_test("loads");
    endtask

    task automatic alu_test(input logic [2:0] op, input logic imm);
        logic [7:0]  a;
        logic [7:0]  b;
        logic        cin;
        logic [2:0]  src;
        logic [15:0] model;
        string       name;
        test_err = 0;
        name = $sformatf("alu op%0d %s", op, imm ? "imm" : "reg");
        for (int i = 0; i < ALU_PAIRS; i++) begin
            a     = 8'($urandom);
            b     = 8'($urandom);
            cin   = 1'($urandom);
            src   = 3'($urandom_range(5, 0));
            model = alu_model(op, a, b, cin);
            begin_program();
            if (cin) begin
                emit(8'h3E);
                emit(8'hFF);
                emit(8'hC6);                    // FF + 1 leaves carry set
                emit(8'h01);
            end
            emit(8'h3E);
            emit(a);
            if (imm) begin
                emit({2'b11, op, 3'b110});
                emit(b);
            end else begin
                emit({2'b00, src, 3'b110});
                emit(b);
                emit({2'b10, op, src});
            end
            emit_out(8'h01, (op == 3'd7) ? a : model[7:0]);
            emit_probe(3'd1, 8'h02, model[15:8]);
            emit_probe(3'd3, 8'h03, model[15:8]);
            emit_probe(3'd5, 8'h04, model[15:8]);
            emit_probe(3'd7, 8'h05, model[15:8]);
            emit(8'h76);
            run_program(0);
            compare_ports(name);
        end
        finish_test(name);
    endtask

    task automatic memory_test();
        logic [15:0] rd_addr;
        logic [15:0] wr_addr;
        logic [7:0]  rd_val;
        logic [7:0]  wr_val;
        test_err = 0;
        rd_addr = {2'b10, 14'($urandom)};
        wr_addr = {2'b11, 14'($urandom)};
        rd_val  = 8'($urandom);
        wr_val  = 8'($urandom);
        begin_program();
        mem[rd_addr] = rd_val;
        emit(8'h3A);
        emit(rd_addr[7:0]);
        emit(rd_addr[15:8]);
        emit_out(8'h40, rd_val);
        emit(8'h3E);
        emit(wr_val);
        emit(8'h32);
        emit(wr_addr[7:0]);
        emit(wr_addr[15:8]);
        emit(8'h76);
        run_program(0);
        compare_ports("memory");
        if (wr_log.size() != 1) begin
            report_mismatch("memory write count", 32'd1, 32'(wr_log.size()));
        end else if (wr_log[0] !== {8'h00, wr_addr, wr_val}) begin
            report_mismatch("memory write bus", {8'h00, wr_addr, wr_val}, wr_log[0]);
        end
        if (mem[wr_addr] !== wr_val) report_mismatch("memory store", 32'(wr_val), 32'(mem[wr_addr]));
        finish_test("memory");
    endtask

    task automatic jump_test();
        logic [15:0] target;
        logic [15:0] model;
        logic [7:0]  a;
        logic [7:0]  b;
        test_err = 0;
        begin_program();
        emit(8'h3E);
        emit(8'h11);
        target = wp + 16'd5;
        emit(8'hC3);
        emit(target[7:0]);
        emit(target[15:8]);
        emit(8'hD3);                            // Jumped over
        emit(8'h50);
        emit_out(8'h51, 8'h11);
        for (int cc = 0; cc < 8; cc++) begin
            a = 8'($urandom);
            b = 8'($urandom);
            if (cc == 1) b = a;                 // Z taken at least once
            model = alu_model(3'd7, a, b, 1'b0);
            emit(8'h3E);
            emit(a);
            emit(8'hFE);                        // CP n
            emit(b);
            emit_probe(3'(cc), 8'(8'h60 + cc), model[15:8]);
        end
        emit(8'h76);
        run_program(0);
        compare_ports("jumps");
        finish_test("jumps");
    endtask

    task automatic port_in_test();
        logic [7:0] n;
        logic [7:0] data;
        test_err = 0;
        n    = {1'b1, 7'($urandom)};
        data = 8'($urandom);
        begin_program();
        pin_pi   = data;
        watch_pa = {8'h00, n};
        emit(8'hDB);
        emit(n);
        emit_out(8'h70, data);
        emit(8'h76);
        run_program(0);
        compare_ports("port in");
        if (!pa_seen) begin
            err_cnt++;
            test_err++;
            $display("Error port in: pin_pa never showed port %h during IN", n);
        end
        finish_test("port in");
    endtask

    task automatic halt_reset_test();
        logic [7:0] v;
        test_err = 0;
        v = 8'($urandom);
        begin_program();
        emit(8'h3E);
        emit(v);
        emit_out(8'h80, v);
        emit(8'h76);
        emit(8'hD3);                            // Past HALT and never reached
        emit(8'h81);
        emit(8'h32);
        emit(8'h00);
        emit(8'h90);
        run_program(20);
        compare_ports("halt");
        if (wr_log.size() != 0) report_mismatch("halt write count", 32'd0, 32'(wr_log.size()));
        // Same program again from a fresh reset
        begin_program();
        expect_port(8'h80, v);
        run_program(60);
        if (first_fetch !== RESET_PC) report_mismatch("reset fetch", 32'(RESET_PC), 32'(first_fetch));
        compare_ports("halt rerun");
        finish_test("halt and reset");
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------

    initial begin
        pin_reset = 1'b1;
        pin_pi    = 8'h00;
        watch_pa  = 16'hFFFF;
        wp        = RESET_PC;
        pa_seen   = 1'b0;
        err_cnt   = 0;
        test_cnt  = 0;
        test_err  = 0;
        void'($urandom(32'hec5b));
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3C;
        end
        repeat (5) @(posedge pin_clk);

        loads_test();
        for (int op = 0; op < 8; op++) begin
            alu_test(3'(op), 1'b0);
            alu_test(3'(op), 1'b1);
        end
        memory_test();
        jump_test();
        port_in_test();
        halt_reset_test();

        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/z80_arch_pkg.sv
hdl/z80_isa_pkg.sv
hdl/z80_regfile_if.sv
hdl/z80_regs.sv
hdl/z80_alu.sv
hdl/z80_control.sv
hdl/z80.sv
sim/tb_z80.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the z80 core and testbench with Verilator, run, and scan the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_z80 \
    -f src.f

./obj_dir/Vtb_z80 > sim.log 2>&1
cat sim.log

if grep -q -x "All checks passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
